// ==== files.f ====
+incdir+verification
verilog/decodePkg.sv
verilog/decodeIfs.sv
verilog/controlDecoder.sv
verilog/operandFetch.sv
verilog/decodeIssue.sv
verilog/decodeStage.sv
verification/decodeStageTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -f files.f --top-module decodeStageTb -Mdir obj_dir

./obj_dir/VdecodeStageTb | tee sim.log

if grep -q "Result: FAILED" sim.log; then
	echo "simulation reported failure"
	exit 1
fi

echo "simulation finished without failure"

// ==== verification/decodeModel.svh ====
`ifndef DECODE_MODEL_SVH
`define DECODE_MODEL_SVH

typedef struct packed {
	logic  regDst;
	logic  branchEq;
	logic  branchNe;
	aluOpT aluOp;
	logic  aluSrc;
	logic  regWrite;
	logic  memWrite;
	logic  memRead;
	logic  memToReg;
	logic  shamtSel;
	logic  jump;
	logic  jumpReg;
	logic  link;
} ctrlModelT;

logic [31:0] shadow [0:31];  // expected register file contents.

// control table built from the MIPS encodings.
function automatic ctrlModelT expectedCtrl(input logic [5:0] op, input logic [5:0] fn);
	ctrlModelT c;
	logic      legalFn;
	c = '0;
	legalFn = 1'b1;
	case (op)
		6'h00: begin
			case (fn)
				6'h20: c.aluOp = aluAdd;
				6'h22: c.aluOp = aluSub;
				6'h24: c.aluOp = aluAnd;
				6'h25: c.aluOp = aluOr;
				6'h2a: c.aluOp = aluSlt;
				6'h00: c.aluOp = aluSll;
				6'h02: c.aluOp = aluSrl;
				6'h08: c.jumpReg = 1'b1;
				default: legalFn = 1'b0;
			endcase
			c.regDst = legalFn;
			c.regWrite = legalFn & ~c.jumpReg;
			c.shamtSel = (fn == 6'h00) || (fn == 6'h02);
		end
		6'h08, 6'h0c, 6'h0d, 6'h0f: begin
			c.aluSrc = 1'b1;
			c.regWrite = 1'b1;
			case (op)
				6'h0c: c.aluOp = aluAnd;
				6'h0d: c.aluOp = aluOr;
				6'h0f: c.aluOp = aluLui;
				default: c.aluOp = aluAdd;
			endcase
		end
		6'h23: begin
			c.memRead = 1'b1;
			c.memToReg = 1'b1;
			c.aluSrc = 1'b1;
			c.regWrite = 1'b1;
		end
		6'h2b: begin
			c.memWrite = 1'b1;
			c.aluSrc = 1'b1;
		end
		6'h04: begin
			c.branchEq = 1'b1;
			c.aluOp = aluSub;
		end
		6'h05: begin
			c.branchNe = 1'b1;
			c.aluOp = aluSub;
		end
		6'h02: c.jump = 1'b1;
		6'h03: begin
			c.jump = 1'b1;
			c.link = 1'b1;
			c.regWrite = 1'b1;
		end
		default: ;  // no-op.
	endcase
	return c;
endfunction

function automatic logic [4:0] expectedDest(input ctrlModelT c, input logic [4:0] rtIdx,
		input logic [4:0] rdIdx);
	if (c.regDst) begin
		return rdIdx;
	end
	return c.link ? 5'd31 : rtIdx;
endfunction

function automatic logic [31:0] shadowRead(input logic [4:0] idx);
	return (idx == 5'd0) ? 32'd0 : shadow[idx];
endfunction

// called once per rising edge with the inputs that were stable before it.
task automatic updateShadow(input logic clear, input logic we, input logic lnk,
		input logic [4:0] idx, input logic [31:0] data);
	logic [4:0] target;
	target = lnk ? 5'd31 : idx;
	if (clear) begin
		for (int k = 0; k < 32; k++) begin
			shadow[k] = 32'd0;
		end
	end else if (we && (target != 5'd0)) begin
		shadow[target] = data;
	end
endtask

`endif

// ==== verification/decodeStageTb.sv ====
`default_nettype none

module decodeStageTb
	import decodePkg::*;
();

	localparam int numCycles   = 2000;
	localparam int resetCycles = 4;
	localparam int cycleLimit  = numCycles + resetCycles + 96;

	logic        clk = 1'b0;
	logic        rst;
	logic [31:0] instr;
	logic        stall;
	logic        wbWrite;
	logic        wbLink;
	regIdxT      wbReg;
	logic [31:0] wbData;

	aluOpT       aluOp;
	regIdxT      destReg;
	logic        branchEq;
	logic        branchNe;
	logic        aluSrc;
	logic        regWrite;
	logic        memWrite;
	logic        memRead;
	logic        memToReg;
	logic        shamtSel;
	logic        jump;
	logic        jumpReg;
	logic        link;
	logic [31:0] readData1;
	logic [31:0] readData2;
	logic [31:0] immExt;
	logic [31:0] shamtExt;

	int          errorCount = 0;
	int          checkCount = 0;
	int          cycleCount = 0;
	logic [31:0] lcgState   = 32'hbe81;

	`include "decodeModel.svh"

	decodeStage #(
		.dataWidth (32)
	) u_dut (
		.clk       (clk),
		.rst       (rst),
		.instr     (instr),
		.stall     (stall),
		.wbWrite   (wbWrite),
		.wbLink    (wbLink),
		.wbReg     (wbReg),
		.wbData    (wbData),
		.aluOp     (aluOp),
		.destReg   (destReg),
		.branchEq  (branchEq),
		.branchNe  (branchNe),
		.aluSrc    (aluSrc),
		.regWrite  (regWrite),
		.memWrite  (memWrite),
		.memRead   (memRead),
		.memToReg  (memToReg),
		.shamtSel  (shamtSel),
		.jump      (jump),
		.jumpReg   (jumpReg),
		.link      (link),
		.readData1 (readData1),
		.readData2 (readData2),
		.immExt    (immExt),
		.shamtExt  (shamtExt)
	);

	always #50 clk = ~clk;

	// upper half only, the low bits of an lcg repeat quickly.
	function automatic logic [15:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState[31:16];
	endfunction

	function automatic logic [5:0] pickOpcode(input logic [3:0] idx);
		case (idx)
			4'd0: return 6'h00;
			4'd1: return 6'h02;
			4'd2: return 6'h03;
			4'd3: return 6'h04;
			4'd4: return 6'h05;
			4'd5: return 6'h08;
			4'd6: return 6'h0c;
			4'd7: return 6'h0d;
			4'd8: return 6'h0f;
			4'd9: return 6'h23;
			default: return 6'h2b;
		endcase
	endfunction

	function automatic logic [5:0] pickFunct(input logic [2:0] idx);
		case (idx)
			3'd0: return 6'h00;
			3'd1: return 6'h02;
			3'd2: return 6'h08;
			3'd3: return 6'h20;
			3'd4: return 6'h22;
			3'd5: return 6'h24;
			3'd6: return 6'h25;
			default: return 6'h2a;
		endcase
	endfunction

	task automatic checkVal(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checkCount++;
		if (actual !== expected) begin
			errorCount++;
			$display("FAIL at %0t: %s is %h, expected %h", $time, name, actual, expected);
		end
	endtask

	task automatic driveInputs();
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] e;
		logic [31:0] body;
		logic [5:0]  op;
		logic [5:0]  fn;
		a = nextRand();
		b = nextRand();
		e = nextRand();
		body = {nextRand(), nextRand()};
		if (a[15:13] == 3'd0) begin
			op = a[5:0];  // mostly an illegal opcode.
		end else begin
			op = pickOpcode(4'(a[12:0] % 13'd11));
		end
		fn = (b[15:12] == 4'd0) ? b[5:0] : pickFunct(b[11:9]);
		if (op == 6'h00) begin
			instr = {op, body[25:6], fn};
		end else begin
			instr = {op, body[25:0]};
		end
		stall = (b[8:6] == 3'd0);
		wbWrite = e[15];
		wbLink = (e[14:12] == 3'd0);
		wbReg = e[4:0];
		wbData = {nextRand(), nextRand()};
	endtask

	task automatic checkOutputs();
		ctrlModelT  c;
		logic [4:0] dest;
		c = expectedCtrl(instr[31:26], instr[5:0]);
		dest = stall ? 5'd0 : expectedDest(c, instr[20:16], instr[15:11]);
		checkVal("aluOp", 32'(aluOp), 32'(c.aluOp));
		checkVal("destReg", 32'(destReg), 32'(dest));
		checkVal("branchEq", 32'(branchEq), 32'(c.branchEq & ~stall));
		checkVal("branchNe", 32'(branchNe), 32'(c.branchNe & ~stall));
		checkVal("aluSrc", 32'(aluSrc), 32'(c.aluSrc));
		checkVal("regWrite", 32'(regWrite), 32'(c.regWrite & ~stall));
		checkVal("memWrite", 32'(memWrite), 32'(c.memWrite & ~stall));
		checkVal("memRead", 32'(memRead), 32'(c.memRead & ~stall));
		checkVal("memToReg", 32'(memToReg), 32'(c.memToReg));
		checkVal("shamtSel", 32'(shamtSel), 32'(c.shamtSel));
		checkVal("jump", 32'(jump), 32'(c.jump & ~stall));
		checkVal("jumpReg", 32'(jumpReg), 32'(c.jumpReg & ~stall));
		checkVal("link", 32'(link), 32'(c.link));
		checkVal("readData1", readData1, shadowRead(instr[25:21]));
		checkVal("readData2", readData2, shadowRead(instr[20:16]));
		checkVal("immExt", immExt, {{16{instr[15]}}, instr[15:0]});
		checkVal("shamtExt", shamtExt, {27'd0, instr[10:6]});
	endtask

	// ************************************************************************
	// main sequence
	// ************************************************************************

	initial begin
		rst = 1'b1;
		instr = 32'd0;
		stall = 1'b0;
		wbWrite = 1'b0;
		wbLink = 1'b0;
		wbReg = 5'd0;
		wbData = 32'd0;
		for (int n = 0; n < resetCycles; n++) begin
			@(posedge clk);
			updateShadow(rst, wbWrite, wbLink, wbReg, wbData);
		end
		for (int n = 0; n < numCycles; n++) begin
			#5;
			rst = 1'b0;
			driveInputs();
			#90;  // just before the next edge.
			checkOutputs();
			@(posedge clk);
			updateShadow(rst, wbWrite, wbLink, wbReg, wbData);
		end
		$display("checks run %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= cycleLimit) begin
			$display("timeout, the run did not end within %0d cycles", cycleLimit);
			$display("Result: FAILED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/controlDecoder.sv ====
`default_nettype none

module controlDecoder
	import decodePkg::*;
(
	input  opcodeT opcode,
	input  functT  funct,
	ctrlBus.src    ctrl
);

	always_comb begin
		ctrl.regDst   = 1'b0;  // everything off unless decoded.
		ctrl.branchEq = 1'b0;
		ctrl.branchNe = 1'b0;
		ctrl.aluOp    = aluAdd;
		ctrl.aluSrc   = 1'b0;
		ctrl.regWrite = 1'b0;
		ctrl.memWrite = 1'b0;
		ctrl.memRead  = 1'b0;
		ctrl.memToReg = 1'b0;
		ctrl.shamtSel = 1'b0;
		ctrl.jump     = 1'b0;
		ctrl.jumpReg  = 1'b0;
		ctrl.link     = 1'b0;

		case (opcode)
			rType: begin
				case (funct)
					fnAdd: begin
						ctrl.regDst   = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.aluOp    = aluAdd;
					end
					fnSub: begin
						ctrl.regDst   = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.aluOp    = aluSub;
					end
					fnAnd: begin
						ctrl.regDst   = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.aluOp    = aluAnd;
					end
					fnOr: begin
						ctrl.regDst   = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.aluOp    = aluOr;
					end
					fnSlt: begin
						ctrl.regDst   = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.aluOp    = aluSlt;
					end
					fnSll: begin
						ctrl.regDst   = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.shamtSel = 1'b1;  // operand b from shamt.
						ctrl.aluOp    = aluSll;
					end
					fnSrl: begin
						ctrl.regDst   = 1'b1;
						ctrl.regWrite = 1'b1;
						ctrl.shamtSel = 1'b1;
						ctrl.aluOp    = aluSrl;
					end
					fnJr: begin
						ctrl.regDst   = 1'b1;
						ctrl.jumpReg  = 1'b1;  // no write-back.
					end
					default: ;  // unknown funct is a no-op.
				endcase
			end

			// ****************************************************************
			// immediate arithmetic and logic
			// ****************************************************************
			addi: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			andi: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluAnd;
			end
			ori: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluOr;
			end
			lui: begin
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluLui;
			end

			// memory, address is base plus offset.
			lw: begin
				ctrl.memRead  = 1'b1;
				ctrl.memToReg = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.regWrite = 1'b1;
				ctrl.aluOp    = aluAdd;
			end
			sw: begin
				ctrl.memWrite = 1'b1;
				ctrl.aluSrc   = 1'b1;
				ctrl.aluOp    = aluAdd;
			end

			beq: begin
				ctrl.branchEq = 1'b1;
				ctrl.aluOp    = aluSub;  // compare by subtract.
			end
			bne: begin
				ctrl.branchNe = 1'b1;
				ctrl.aluOp    = aluSub;
			end

			j: ctrl.jump = 1'b1;
			jal: begin
				ctrl.jump     = 1'b1;
				ctrl.link     = 1'b1;  // pc+4 into r31.
				ctrl.regWrite = 1'b1;
			end

			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== verilog/decodeIfs.sv ====
`default_nettype none

// raw controls, decoder to issue.
interface ctrlBus
	import decodePkg::*;
();
	logic  regDst;
	logic  branchEq;
	logic  branchNe;
	aluOpT aluOp;
	logic  aluSrc;
	logic  regWrite;
	logic  memWrite;
	logic  memRead;
	logic  memToReg;
	logic  shamtSel;
	logic  jump;
	logic  jumpReg;
	logic  link;

	modport src (output regDst, branchEq, branchNe, aluOp, aluSrc, regWrite,
		memWrite, memRead, memToReg, shamtSel, jump, jumpReg, link);
	modport dst (input regDst, branchEq, branchNe, aluOp, aluSrc, regWrite,
		memWrite, memRead, memToReg, shamtSel, jump, jumpReg, link);
endinterface

// operands, fetch to issue.
interface operandBus #(
	parameter int dataWidth = 32
) ();
	logic [dataWidth-1:0] readData1;
	logic [dataWidth-1:0] readData2;
	logic [dataWidth-1:0] immExt;
	logic [dataWidth-1:0] shamtExt;

	modport src (output readData1, readData2, immExt, shamtExt);
	modport dst (input readData1, readData2, immExt, shamtExt);
endinterface

`default_nettype wire

// ==== verilog/decodeIssue.sv ====
`default_nettype none

module decodeIssue
	import decodePkg::*;
#(
	parameter int dataWidth = 32
) (
	input  logic                 stall,
	input  regIdxT               rt,
	input  regIdxT               rd,
	ctrlBus.dst                  ctrl,
	operandBus.dst               opnd,

	output aluOpT                aluOp,
	output regIdxT               destReg,
	output logic                 branchEq,
	output logic                 branchNe,
	output logic                 aluSrc,
	output logic                 regWrite,
	output logic                 memWrite,
	output logic                 memRead,
	output logic                 memToReg,
	output logic                 shamtSel,
	output logic                 jump,
	output logic                 jumpReg,
	output logic                 link,
	output logic [dataWidth-1:0] readData1,
	output logic [dataWidth-1:0] readData2,
	output logic [dataWidth-1:0] immExt,
	output logic [dataWidth-1:0] shamtExt
);

	regIdxT dest;

	always_comb begin
		if (ctrl.regDst) begin
			dest = rd;
		end else if (ctrl.link) begin
			dest = linkReg;
		end else begin
			dest = rt;
		end
	end

	assign destReg = stall ? zeroReg : dest;  // bubble writes nothing.

	// side effects are cancelled under stall.
	assign branchEq = ctrl.branchEq & ~stall;
	assign branchNe = ctrl.branchNe & ~stall;
	assign regWrite = ctrl.regWrite & ~stall;
	assign memWrite = ctrl.memWrite & ~stall;
	assign memRead  = ctrl.memRead & ~stall;
	assign jump     = ctrl.jump & ~stall;
	assign jumpReg  = ctrl.jumpReg & ~stall;

	assign aluOp    = ctrl.aluOp;  // harmless, pass through.
	assign aluSrc   = ctrl.aluSrc;
	assign memToReg = ctrl.memToReg;
	assign shamtSel = ctrl.shamtSel;
	assign link     = ctrl.link;

	assign readData1 = opnd.readData1;
	assign readData2 = opnd.readData2;
	assign immExt    = opnd.immExt;
	assign shamtExt  = opnd.shamtExt;

endmodule

`default_nettype wire

// ==== verilog/decodePkg.sv ====
`default_nettype none

package decodePkg;

	// ************************************************************************
	// primary opcode field, instr[31:26]
	// ************************************************************************

	typedef enum logic [5:0] {
		rType = 6'h00,  // register format, see funct.
		j     = 6'h02,
		jal   = 6'h03,
		beq   = 6'h04,
		bne   = 6'h05,
		addi  = 6'h08,
		andi  = 6'h0c,
		ori   = 6'h0d,
		lui   = 6'h0f,
		lw    = 6'h23,
		sw    = 6'h2b
	} opcodeT;

	// ************************************************************************
	// function field of r-type, instr[5:0]
	// ************************************************************************

	typedef enum logic [5:0] {
		fnSll = 6'h00,
		fnSrl = 6'h02,
		fnJr  = 6'h08,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr  = 6'h25,
		fnSlt = 6'h2a
	} functT;

	// operation handed to execute.
	typedef enum logic [2:0] {
		aluAdd = 3'd0,  // also the no-op encoding.
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOr  = 3'd3,
		aluSlt = 3'd4,
		aluSll = 3'd5,
		aluSrl = 3'd6,
		aluLui = 3'd7
	} aluOpT;

	// ************************************************************************
	// register indices
	// ************************************************************************

	typedef logic [4:0] regIdxT;

	localparam regIdxT zeroReg = 5'd0;   // hardwired zero.
	localparam regIdxT linkReg = 5'd31;  // jal return address.

endpackage

`default_nettype wire

// ==== verilog/decodeStage.sv ====
`default_nettype none

module decodeStage
	import decodePkg::*;
#(
	parameter int dataWidth = 32
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [31:0]          instr,
	input  logic                 stall,
	input  logic                 wbWrite,
	input  logic                 wbLink,
	input  regIdxT               wbReg,
	input  logic [dataWidth-1:0] wbData,

	output aluOpT                aluOp,
	output regIdxT               destReg,
	output logic                 branchEq,
	output logic                 branchNe,
	output logic                 aluSrc,
	output logic                 regWrite,
	output logic                 memWrite,
	output logic                 memRead,
	output logic                 memToReg,
	output logic                 shamtSel,
	output logic                 jump,
	output logic                 jumpReg,
	output logic                 link,
	output logic [dataWidth-1:0] readData1,
	output logic [dataWidth-1:0] readData2,
	output logic [dataWidth-1:0] immExt,
	output logic [dataWidth-1:0] shamtExt
);

	// ************************************************************************
	// instruction fields
	// ************************************************************************

	opcodeT      opcode;
	functT       funct;
	regIdxT      rs;
	regIdxT      rt;
	regIdxT      rd;
	logic [4:0]  shamt;
	logic [15:0] imm16;

	assign opcode = opcodeT'(instr[31:26]);
	assign funct  = functT'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign shamt  = instr[10:6];
	assign imm16  = instr[15:0];

	ctrlBus                              ctrlIf ();
	operandBus #(.dataWidth(dataWidth)) opndIf ();

	controlDecoder controlUnit (
		.opcode (opcode),
		.funct  (funct),
		.ctrl   (ctrlIf.src)
	);

	operandFetch #(
		.dataWidth (dataWidth)
	) operandUnit (
		.clk     (clk),
		.rst     (rst),
		.wbWrite (wbWrite),
		.wbLink  (wbLink),
		.wbReg   (wbReg),
		.wbData  (wbData),
		.rs      (rs),
		.rt      (rt),
		.imm16   (imm16),
		.shamt   (shamt),
		.opnd    (opndIf.src)
	);

	decodeIssue #(
		.dataWidth (dataWidth)
	) issueUnit (
		.stall     (stall),
		.rt        (rt),
		.rd        (rd),
		.ctrl      (ctrlIf.dst),
		.opnd      (opndIf.dst),
		.aluOp     (aluOp),
		.destReg   (destReg),
		.branchEq  (branchEq),
		.branchNe  (branchNe),
		.aluSrc    (aluSrc),
		.regWrite  (regWrite),
		.memWrite  (memWrite),
		.memRead   (memRead),
		.memToReg  (memToReg),
		.shamtSel  (shamtSel),
		.jump      (jump),
		.jumpReg   (jumpReg),
		.link      (link),
		.readData1 (readData1),
		.readData2 (readData2),
		.immExt    (immExt),
		.shamtExt  (shamtExt)
	);

endmodule

`default_nettype wire

// ==== verilog/operandFetch.sv ====
`default_nettype none

module operandFetch
	import decodePkg::*;
#(
	parameter int dataWidth = 32
) (
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 wbWrite,
	input  logic                 wbLink,
	input  regIdxT               wbReg,
	input  logic [dataWidth-1:0] wbData,
	input  regIdxT               rs,
	input  regIdxT               rt,
	input  logic [15:0]          imm16,
	input  logic [4:0]           shamt,
	operandBus.src               opnd
);

	logic [dataWidth-1:0] regs [0:31];
	regIdxT               wrIdx;

	// ************************************************************************
	// register file
	// ************************************************************************

	assign wrIdx = wbLink ? linkReg : wbReg;  // jal return goes to r31.

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wbWrite && (wrIdx != zeroReg)) begin
			regs[wrIdx] <= wbData;
		end
	end

	// no write-through, new data shows next cycle.
	always_comb begin
		if (rs == zeroReg) begin
			opnd.readData1 = '0;
		end else begin
			opnd.readData1 = regs[rs];
		end

		if (rt == zeroReg) begin
			opnd.readData2 = '0;
		end else begin
			opnd.readData2 = regs[rt];
		end
	end

	// ************************************************************************
	// extenders
	// ************************************************************************

	assign opnd.immExt   = {{(dataWidth-16){imm16[15]}}, imm16};  // sign.
	assign opnd.shamtExt = {{(dataWidth-5){1'b0}}, shamt};        // zero fill.

endmodule

`default_nettype wire
